// File: icache_top.f
src/icache_pkg.sv
src/line_ram_1r1w.sv
src/icache_refill.sv
src/icache_ctrl.sv
src/icache_top.sv
dv/icache_mem_model.sv
dv/icache_checker.sv
dv/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  # package first, the RTL modules import it
  - files:
      - src/icache_pkg.sv
      - src/line_ram_1r1w.sv
      - src/icache_refill.sv
      - src/icache_ctrl.sv
      - src/icache_top.sv
  # simulation only
  - target: test
    files:
      - dv/icache_mem_model.sv
      - dv/icache_checker.sv
      - dv/icache_tb.sv

// File: dv/icache_tb.sv
// ================================================
// directed tests of the instruction cache against a rule-based memory
// outputs are sampled at the rising edge, inputs change after it
// stops at the first mismatch or timeout
// ================================================
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

   import icache_pkg::*;

   localparam int    MAX_CLOCKS = 200;            // limit for one CPU read, misses included
   localparam int    HIT_CLOCKS = 2;              // first stb edge to ack on a hit
   localparam int    LINE_BEATS = 8;              // words fetched per refill
   localparam addr_t ADR_A      = 32'h0000_1234;
   localparam addr_t ADR_B      = ADR_A + 32'h0000_8000;   // same index, next tag
   localparam addr_t ADR_ERR    = 32'hf000_0040;           // inside the error window

   logic  clk;
   logic  rst_n;
   logic  inv;
   logic  cpu_cyc;
   logic  cpu_stb;
   addr_t cpu_adr;
   logic  cpu_ack;
   logic  cpu_err;
   word_t cpu_dat;
   logic  mem_cyc;
   logic  mem_stb;
   logic  mem_we;
   addr_t mem_adr;
   logic  mem_ack;
   logic  mem_err;
   word_t mem_dat;

   // what the last CPU read saw
   word_t last_dat;
   logic  last_ack;
   logic  last_err;
   logic  last_mem;      // mem_cyc was seen high during the read
   int    last_clocks;   // edges from the first stb edge to the answer
   int    last_beats;    // memory acks counted during the read

   icache_top uut (
      .clk, .rst_n, .inv,
      .cpu_cyc, .cpu_stb, .cpu_adr, .cpu_ack, .cpu_err, .cpu_dat,
      .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_ack, .mem_err, .mem_dat
   );

   icache_mem_model memory (
      .clk, .rst_n, .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_ack, .mem_err, .mem_dat
   );

   always #50 clk = ~clk;   // 100 ns period

   // ================================================
   // reporting and compares
   // ================================================
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   // a failed bus property ends the run like any other mismatch
   always @(posedge clk) begin
      if (uut.bus_checks.failures != 0) begin
         abort_run("a bus protocol assertion failed");
      end
   end

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
      end
   endtask

   // the memory's contents, rotate left by 7 then flip the fixed upper pattern
   function automatic word_t expected_word(input addr_t a);
      return {a[24:0], a[31:25]} ^ 32'h5a5a_0000;
   endfunction

   // ================================================
   // CPU bus driver
   // ================================================
   task automatic cpu_read(input addr_t adr);
      bit done;
      @(posedge clk);
      cpu_cyc <= 1'b1;
      cpu_stb <= 1'b1;
      cpu_adr <= adr;
      last_clocks = 0;
      last_beats  = 0;
      last_mem    = 1'b0;
      done        = 1'b0;
      @(posedge clk);   // first edge that sees stb
      while (!done) begin
         @(posedge clk);
         last_clocks++;
         if (mem_ack) last_beats++;
         if (mem_cyc) last_mem = 1'b1;
         if (mem_stb) begin
            check_flag("mem_we", mem_we, 1'b0);   // the cache only reads memory
         end
         if (cpu_ack || cpu_err) begin
            done = 1'b1;
         end else if (last_clocks >= MAX_CLOCKS) begin
            abort_run($sformatf("the cache never answered the read of %h", adr));
         end
      end
      last_dat = cpu_dat;   // registered together with ack, stable through this cycle
      last_ack = cpu_ack;
      last_err = cpu_err;
      cpu_cyc <= 1'b0;
      cpu_stb <= 1'b0;
   endtask

   // read that must succeed with the memory's word
   task automatic read_and_check(input addr_t adr);
      cpu_read(adr);
      check_flag("cpu_ack", last_ack, 1'b1);
      check_flag("cpu_err", last_err, 1'b0);
      check_word("cpu_dat", last_dat, expected_word(adr));
   endtask

   // ================================================
   // directed tests
   // ================================================
   task automatic cold_miss_test();
      read_and_check(ADR_A);
      check_count("mem beats", last_beats, LINE_BEATS);
   endtask

   task automatic hit_test();
      addr_t base;
      base = {ADR_A[31:5], 5'b0};
      for (int w = 0; w < LINE_BEATS; w++) begin
         read_and_check(base + addr_t'(w * 4));
         check_count("hit latency", last_clocks, HIT_CLOCKS);
         check_flag("mem_cyc", last_mem, 1'b0);   // a hit never touches memory
      end
   endtask

   task automatic conflict_test();
      read_and_check(ADR_B);
      check_count("mem beats", last_beats, LINE_BEATS);
      read_and_check(ADR_A);   // B evicted A, so this refills again
      check_count("mem beats", last_beats, LINE_BEATS);
   endtask

   task automatic invalidate_test();
      read_and_check(ADR_A);
      check_flag("mem_cyc", last_mem, 1'b0);
      @(posedge clk);
      inv <= 1'b1;
      @(posedge clk);
      inv <= 1'b0;
      read_and_check(ADR_A);
      check_flag("mem_cyc", last_mem, 1'b1);
   endtask

   task automatic bus_error_test();
      for (int n = 0; n < 2; n++) begin   // the second read shows the line stayed invalid
         cpu_read(ADR_ERR);
         check_flag("cpu_err", last_err, 1'b1);
         check_flag("cpu_ack", last_ack, 1'b0);
         check_flag("mem_cyc", last_mem, 1'b1);
      end
   endtask

   task automatic random_sweep();
      addr_t adr;
      // a 128 KiB window, four times the cache, mixes hits with conflict misses
      for (int n = 0; n < 200; n++) begin
         adr = 32'h0001_0000 + ($urandom % 32'h0002_0000);
         adr[1:0] = 2'b00;
         read_and_check(adr);
      end
   endtask

   // ================================================
   // run
   // ================================================
   initial begin
      void'($urandom(32'hcae75a69));
      clk     = 1'b0;
      rst_n   = 1'b0;
      inv     = 1'b0;
      cpu_cyc = 1'b0;
      cpu_stb = 1'b0;
      cpu_adr = '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      cold_miss_test();
      hit_test();
      conflict_test();
      invalidate_test();
      bus_error_test();
      random_sweep();
      @(posedge clk);   // properties sampled at the last answer have settled by now
      if (uut.bus_checks.failures != 0) begin
         abort_run("a bus protocol assertion failed");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: dv/icache_checker.sv
// ================================================
// bus protocol assertions, bound into icache_top
// all properties are off while rst_n is low
// ================================================
`timescale 1ns/1ps
`default_nettype none

module icache_checker (
   input wire logic              clk,
   input wire logic              rst_n,
   input wire logic              cpu_stb,
   input wire logic              cpu_ack,
   input wire logic              cpu_err,
   input wire logic              mem_cyc,
   input wire logic              mem_stb,
   input wire icache_pkg::addr_t mem_adr,
   input wire logic              mem_ack,
   input wire logic              mem_err
);

   int failures = 0;   // properties that have failed so far

   // the CPU gets one kind of answer per request
   ack_err_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
      !(cpu_ack && cpu_err))
      else begin
         $error("cpu_ack and cpu_err are high together");
         failures++;
      end

   // an answer only goes to a request that is still on the bus
   ack_needs_stb : assert property (@(posedge clk) disable iff (!rst_n)
      ($rose(cpu_ack) || $rose(cpu_err)) |-> cpu_stb)
      else begin
         $error("cpu answer rose without cpu_stb");
         failures++;
      end

   stb_needs_cyc : assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb |-> mem_cyc)
      else begin
         $error("mem_stb high outside a bus cycle");
         failures++;
      end

   // the address belongs to the beat until memory answers it
   adr_held : assert property (@(posedge clk) disable iff (!rst_n)
      (mem_stb && !mem_ack && !mem_err) |=> $stable(mem_adr))
      else begin
         $error("mem_adr moved before the beat was answered");
         failures++;
      end

endmodule

bind icache_top icache_checker bus_checks (
   .clk, .rst_n, .cpu_stb, .cpu_ack, .cpu_err,
   .mem_cyc, .mem_stb, .mem_adr, .mem_ack, .mem_err
);

`default_nettype wire

// File: dv/icache_mem_model.sv
// ================================================
// Wishbone classic memory slave for simulation only
// word at byte address a is a rotated left by 7, xor 32'h5a5a0000
// addresses from 32'hf000_0000 up answer with err, 0 to 3 wait states
// ================================================
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              mem_cyc,
   input  wire logic              mem_stb,
   input  wire logic              mem_we,
   input  wire icache_pkg::addr_t mem_adr,
   output      logic              mem_ack,
   output      logic              mem_err,
   output      icache_pkg::word_t mem_dat
);

   import icache_pkg::*;

   localparam addr_t ERR_BASE = 32'hf000_0000;   // start of the error window

   logic       busy;    // a beat has been seen and is counting down its wait states
   logic [1:0] waits;   // wait states still to go for the current beat

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_ack <= 1'b0;
         mem_err <= 1'b0;
         mem_dat <= '0;
         busy    <= 1'b0;
         waits   <= '0;
      end else begin
         mem_ack <= 1'b0;   // one pulse per beat
         mem_err <= 1'b0;
         if (!mem_cyc) begin
            busy <= 1'b0;
         end else if (mem_stb && !mem_ack && !mem_err) begin
            if (!busy) begin
               busy  <= 1'b1;
               waits <= 2'($urandom % 4);   // fresh wait count for every beat
            end else if (waits != 0) begin
               waits <= waits - 2'd1;
            end else begin
               busy <= 1'b0;
               // writes are refused, nothing in this project should issue one
               if (mem_we || (mem_adr >= ERR_BASE)) begin
                  mem_err <= 1'b1;
               end else begin
                  mem_ack <= 1'b1;
                  mem_dat <= {mem_adr[24:0], mem_adr[31:25]} ^ 32'h5a5a_0000;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: src/icache_top.sv
// ================================================
// direct-mapped read-only instruction cache, 32 KiB
// CPU side is a Wishbone classic slave, memory side a Wishbone classic master
// inv clears every valid bit, a memory error answers the CPU with err
// ================================================
`timescale 1ns/1ps
`default_nettype none

module icache_top (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              inv,
   // CPU bus
   input  wire logic              cpu_cyc,
   input  wire logic              cpu_stb,
   input  wire icache_pkg::addr_t cpu_adr,
   output      logic              cpu_ack,
   output      logic              cpu_err,
   output      icache_pkg::word_t cpu_dat,
   // memory bus
   output      logic              mem_cyc,
   output      logic              mem_stb,
   output      logic              mem_we,
   output      icache_pkg::addr_t mem_adr,
   input  wire logic              mem_ack,
   input  wire logic              mem_err,
   input  wire icache_pkg::word_t mem_dat
);

   import icache_pkg::*;

   index_t rd_index;
   index_t wr_index;
   line_t  rd_line;
   line_t  refill_line;
   tag_t   rd_tag;
   tag_t   wr_tag;
   logic   wr_en;
   logic   refill_start;
   logic   refill_done;
   logic   refill_fail;
   addr_t  refill_adr;

   icache_ctrl ctrl (
      .clk, .rst_n, .inv,
      .cpu_cyc, .cpu_stb, .cpu_adr, .cpu_ack, .cpu_err, .cpu_dat,
      .rd_index, .rd_line, .rd_tag,
      .wr_en, .wr_index, .wr_tag,
      .refill_start, .refill_adr, .refill_done, .refill_fail
   );

   icache_refill refill (
      .clk, .rst_n,
      .refill_start, .refill_adr, .refill_done, .refill_fail, .refill_line,
      .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_ack, .mem_err, .mem_dat
   );

   // data and tag share index and write strobe, only the payload differs
   line_ram_1r1w #(.payload_t(line_t), .depth(N_LINES)) data_ram (
      .clk, .wr(wr_en), .wadr(wr_index), .radr(rd_index), .i(refill_line), .o(rd_line)
   );

   line_ram_1r1w #(.payload_t(tag_t), .depth(N_LINES)) tag_ram (
      .clk, .wr(wr_en), .wadr(wr_index), .radr(rd_index), .i(wr_tag), .o(rd_tag)
   );

endmodule

`default_nettype wire

// File: src/icache_ctrl.sv
// ================================================
// lookup, valid bits and CPU-side Wishbone classic slave
// a hit acks two clocks after stb is first seen, a miss waits for the refill
// one request at a time, a new one is taken the cycle after ack or err
// ================================================
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               inv,
   // CPU bus
   input  wire logic               cpu_cyc,
   input  wire logic               cpu_stb,
   input  wire icache_pkg::addr_t  cpu_adr,
   output      logic               cpu_ack,
   output      logic               cpu_err,
   output      icache_pkg::word_t  cpu_dat,
   // RAM read side
   output      icache_pkg::index_t rd_index,
   input  wire icache_pkg::line_t  rd_line,
   input  wire icache_pkg::tag_t   rd_tag,
   // RAM write side
   output      logic               wr_en,
   output      icache_pkg::index_t wr_index,
   output      icache_pkg::tag_t   wr_tag,
   // refill engine
   output      logic               refill_start,
   output      icache_pkg::addr_t  refill_adr,
   input  wire logic               refill_done,
   input  wire logic               refill_fail
);

   import icache_pkg::*;

   typedef enum logic [1:0] {
      st_idle,     // RAMs read at the incoming address
      st_lookup,   // tag and valid compared against the read result
      st_refill,   // waiting on the refill engine
      st_replay    // line re-read through the RAM bypass, answer the CPU
   } state_t;

   state_t              state;
   addr_t               req_adr;    // address of the request being served
   logic                req_drop;   // CPU gave up the cycle while the refill ran
   logic [N_LINES-1:0]  valid;
   logic                new_req;
   logic                live;
   logic                hit;
   index_t              req_index;
   tag_t                req_tag;

   assign req_index = req_adr[TAG_LO-1:IDX_LO];
   assign req_tag   = req_adr[31:TAG_LO];

   // the previous answer is still visible at this edge, so it is not a new request
   assign new_req = cpu_cyc && cpu_stb && !cpu_ack && !cpu_err;
   assign live    = cpu_cyc && cpu_stb && !req_drop;   // CPU still wants this answer
   assign hit     = valid[req_index] && (rd_tag == req_tag);

   // ================================================
   // RAM and refill hookup
   // ================================================
   // in idle the RAMs look up the bus address directly, that saves a clock on hits
   assign rd_index   = (state == st_idle) ? cpu_adr[TAG_LO-1:IDX_LO] : req_index;
   assign wr_en      = (state == st_refill) && refill_done;   // data and tag written together
   assign wr_index   = req_index;
   assign wr_tag     = req_tag;
   assign refill_adr = req_adr;

   // ================================================
   // request FSM
   // ================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= st_idle;
         cpu_ack      <= 1'b0;
         cpu_err      <= 1'b0;
         refill_start <= 1'b0;
         req_drop     <= 1'b0;
      end else begin
         cpu_ack      <= 1'b0;   // all three are one-cycle pulses
         cpu_err      <= 1'b0;
         refill_start <= 1'b0;
         case (state)
            st_idle: begin
               if (new_req) begin
                  state    <= st_lookup;
                  req_drop <= 1'b0;
               end
            end
            st_lookup: begin
               if (!(cpu_cyc && cpu_stb)) begin
                  state <= st_idle;   // request withdrawn, no refill for it
               end else if (hit) begin
                  cpu_ack <= 1'b1;
                  state   <= st_idle;
               end else begin
                  refill_start <= 1'b1;
                  state        <= st_refill;
               end
            end
            st_refill: begin
               if (!cpu_cyc) begin
                  req_drop <= 1'b1;   // the line is still filled, only the answer is lost
               end
               if (refill_done) begin
                  state <= st_replay;
               end else if (refill_fail) begin
                  cpu_err <= live;
                  state   <= st_idle;
               end
            end
            st_replay: begin
               cpu_ack <= live;   // bypass data is good even if inv hit the valid bit meanwhile
               state   <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // ================================================
   // valid bits
   // ================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= '0;
      end else if (inv) begin
         valid <= '0;   // wins over a fill in the same cycle
      end else if (wr_en) begin
         valid[req_index] <= 1'b1;
      end
   end

   // request address and read data
   always_ff @(posedge clk) begin
      if ((state == st_idle) && new_req) begin
         req_adr <= cpu_adr;
      end
      if ((state == st_lookup) || (state == st_replay)) begin
         cpu_dat <= rd_line[req_adr[IDX_LO-1:2]];   // offset bits [4:2] pick the word
      end
   end

endmodule

`default_nettype wire

// File: src/icache_refill.sv
// ================================================
// Wishbone classic master that fetches one cache line
// eight single reads at rising word addresses, one in flight at a time
// any bus error ends the cycle at once and the line is thrown away
// ================================================
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
   input  wire logic              clk,
   input  wire logic              rst_n,
   // request from the controller
   input  wire logic              refill_start,
   input  wire icache_pkg::addr_t refill_adr,
   output      logic              refill_done,
   output      logic              refill_fail,
   output      icache_pkg::line_t refill_line,
   // memory bus
   output      logic              mem_cyc,
   output      logic              mem_stb,
   output      logic              mem_we,
   output      icache_pkg::addr_t mem_adr,
   input  wire logic              mem_ack,
   input  wire logic              mem_err,
   input  wire icache_pkg::word_t mem_dat
);

   import icache_pkg::*;

   typedef enum logic {
      st_idle,   // waiting for refill_start
      st_bus     // cycle open, one beat outstanding
   } state_t;

   state_t            state;
   beat_t             beat;        // beat currently on the bus
   logic [31:IDX_LO]  line_base;   // tag and index of the line being fetched
   line_t             line_q;      // words shift in from the top

   localparam beat_t LAST_BEAT = beat_t'(WORDS_PER_LINE - 1);

   // ================================================
   // bus outputs
   // ================================================
   // cyc and stb stay up for the whole line, the address moves on after each ack
   assign mem_cyc     = (state == st_bus);
   assign mem_stb     = (state == st_bus);
   assign mem_we      = 1'b0;                            // the cache never writes memory
   assign mem_adr     = {line_base, beat, 2'b00};        // word aligned, beat picks the word
   assign refill_line = line_q;

   // ================================================
   // beat sequencing
   // ================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= st_idle;
         beat        <= '0;
         refill_done <= 1'b0;
         refill_fail <= 1'b0;
      end else begin
         refill_done <= 1'b0;   // both replies are single-cycle pulses
         refill_fail <= 1'b0;
         case (state)
            st_idle: begin
               if (refill_start) begin
                  state <= st_bus;
                  beat  <= '0;   // always start at word 0 of the line
               end
            end
            st_bus: begin
               if (mem_err) begin
                  // abandon the line, the controller leaves it invalid
                  state       <= st_idle;
                  refill_fail <= 1'b1;
               end else if (mem_ack) begin
                  if (beat == LAST_BEAT) begin
                     state       <= st_idle;
                     refill_done <= 1'b1;   // line_q holds all eight words in this cycle
                  end else begin
                     beat <= beat + 1'b1;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // ================================================
   // line assembly
   // ================================================
   always_ff @(posedge clk) begin
      if ((state == st_idle) && refill_start) begin
         line_base <= refill_adr[31:IDX_LO];   // offset bits of the miss address are dropped
      end
      if ((state == st_bus) && mem_ack && !mem_err) begin
         // after eight shifts the first word fetched lands in slot 0
         line_q <= {mem_dat, line_q[WORDS_PER_LINE-1:1]};
      end
   end

endmodule

`default_nettype wire

// File: src/line_ram_1r1w.sv
// ================================================
// simple dual-port RAM, one write and one read port, one clock
// read data appears one clock after the read address
// a same-cycle write and read of one address returns the new data
// ================================================
`timescale 1ns/1ps
`default_nettype none

module line_ram_1r1w #(
   parameter type payload_t = logic,
   parameter int  depth     = icache_pkg::N_LINES
) (
   input  wire logic              clk,
   input  wire logic              wr,
   input  wire icache_pkg::index_t wadr,
   input  wire icache_pkg::index_t radr,
   input  wire payload_t          i,
   output      payload_t          o
);

   import icache_pkg::*;

   payload_t mem [depth];   // the storage array, contents are undefined until written
   payload_t ram_q;         // raw registered read data, may be stale on a collision

   // write side copied one cycle later so a collision can be detected
   logic     wr_q;
   index_t   wadr_q;
   payload_t i_q;
   index_t   radr_q;        // address that produced ram_q

   // ================================================
   // array access
   // ================================================
   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wadr] <= i;
      end
      ram_q <= mem[radr];   // read-first, so the old word comes out on a collision
   end

   always_ff @(posedge clk) begin
      wr_q   <= wr;
      wadr_q <= wadr;
      i_q    <= i;
      radr_q <= radr;
   end

   // forward the freshly written payload when the read hit the address being written
   always_comb begin
      if (wr_q && (wadr_q == radr_q)) begin
         o = i_q;
      end else begin
         o = ram_q;
      end
   end

endmodule

`default_nettype wire

// File: src/icache_pkg.sv
// ================================================
// shared types and constants of the instruction cache
// direct mapped, 1024 lines of 256 bits, 32-bit byte addresses
// word 0 of a line sits in the lowest bits
// ================================================
`default_nettype none

package icache_pkg;

   // ================================================
   // address split
   // ================================================
   localparam int IDX_LO         = 5;     // bits [4:0] are the byte offset inside a line
   localparam int TAG_LO         = 15;    // bits [14:5] select the line
   localparam int N_LINES        = 1024;  // number of lines in the data and tag RAMs
   localparam int WORDS_PER_LINE = 8;     // a refill reads this many 32-bit words

   // byte address as seen on both buses
   typedef logic [31:0] addr_t;

   // one instruction word
   typedef logic [31:0] word_t;

   // a full cache line, word 0 in bits [31:0]
   typedef word_t [WORDS_PER_LINE-1:0] line_t;

   // upper address bits kept in the tag RAM
   typedef logic [31-TAG_LO:0] tag_t;

   // line index, also the RAM address
   typedef logic [TAG_LO-IDX_LO-1:0] index_t;

   // counts the beats of one refill
   typedef logic [$clog2(WORDS_PER_LINE)-1:0] beat_t;

endpackage

`default_nettype wire
